// ==== common/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define XLEN        32
`define REG_ADDR_W  5

// primary opcodes
`define R_TYPE          6'b000000
`define REGIMM_INST     6'b000001
`define J               6'b000010
`define JAL             6'b000011
`define BEQ             6'b000100
`define BNE             6'b000101
`define BLEZ            6'b000110
`define BGTZ            6'b000111
`define ADDI            6'b001000
`define ADDIU           6'b001001
`define SLTI            6'b001010
`define SLTIU           6'b001011
`define ANDI            6'b001100
`define ORI             6'b001101
`define XORI            6'b001110
`define LUI             6'b001111
`define COP0_INST       6'b010000
`define SPECIAL2_INST   6'b011100
`define SPECIAL3_INST   6'b011111
`define LB              6'b100000
`define LH              6'b100001
`define LWL             6'b100010
`define LW              6'b100011
`define LBU             6'b100100
`define LHU             6'b100101
`define LWR             6'b100110
`define SB              6'b101000
`define SH              6'b101001
`define SWL             6'b101010
`define SW              6'b101011
`define SWR             6'b101110
`define LL              6'b110000

// SPECIAL funct
`define SLL             6'b000000
`define SRL             6'b000010
`define SRA             6'b000011
`define SLLV            6'b000100
`define SRLV            6'b000110
`define SRAV            6'b000111
`define JR              6'b001000
`define JALR            6'b001001
`define MOVZ            6'b001010
`define MOVN            6'b001011
`define SYSCALL         6'b001100
`define BREAK           6'b001101
`define MFHI            6'b010000
`define MTHI            6'b010001
`define MFLO            6'b010010
`define MTLO            6'b010011
`define MULT            6'b011000
`define MULTU           6'b011001
`define DIV             6'b011010
`define DIVU            6'b011011
`define ADD             6'b100000
`define ADDU            6'b100001
`define SUB             6'b100010
`define SUBU            6'b100011
`define AND             6'b100100
`define OR              6'b100101
`define XOR             6'b100110
`define NOR             6'b100111
`define SLT             6'b101010
`define SLTU            6'b101011

// REGIMM rt codes
`define BLTZ            5'b00000
`define BGEZ            5'b00001
`define BLTZAL          5'b10000
`define BGEZAL          5'b10001

// COP0 rs codes
`define MFC0            5'b00000
`define MTC0            5'b00100
`define ERET            26'h200_0018   // whole low 26 bits

// SPECIAL2 funct
`define MADD            6'b000000
`define MADDU           6'b000001
`define MUL             6'b000010
`define MSUB            6'b000100
`define MSUBU           6'b000101
`define CLZ             6'b100000
`define CLO             6'b100001

// SPECIAL3 funct and BSHFL sa
`define EXT             6'b000000
`define INS             6'b000100
`define BSHFL           6'b100000
`define WSBH            5'b00010
`define SEB             5'b10000
`define SEH             5'b11000

`endif

// ==== common/mipsPkg.sv ====
`include "mips_consts.svh"

package mipsPkg;

	// one word read three ways
	typedef union packed {
		struct packed {
			logic [5:0]             op;
			logic [`REG_ADDR_W-1:0] rs;
			logic [`REG_ADDR_W-1:0] rt;
			logic [`REG_ADDR_W-1:0] rd;
			logic [4:0]             shamt;
			logic [5:0]             funct;
		} rFmt;
		struct packed {
			logic [5:0]             op;
			logic [`REG_ADDR_W-1:0] rs;
			logic [`REG_ADDR_W-1:0] rt;
			logic [15:0]            imm16;
		} iFmt;
		struct packed {
			logic [5:0]  op;
			logic [25:0] index26;
		} jFmt;
	} instrWord;

	typedef enum logic [5:0] {
		rType, addi, addiu, slti, sltiu, andi, ori, xori, lui, mem,
		rotr, rotrv, mtc0, mfc0, clo, clz, mul, madd, maddu, msub, msubu,
		seb, seh, wsbh, ext, ins, useless
	} aluOpT;

	typedef enum logic [1:0] {rd = 2'b00, rt = 2'b01, ra = 2'b10} regDstT;

	typedef enum logic [2:0] {
		none = 3'd0, eq = 3'd1, ne = 3'd2, lez = 3'd3, gtz = 3'd4, ltz = 3'd5, gez = 3'd6
	} branchCondT;

	typedef struct packed {
		logic       signExt;
		regDstT     regDst;
		logic       useImm;
		logic       regWrite;
		logic       memRead;
		logic       memWrite;
		logic       memToReg;
		logic       hiloToReg;
		logic       isMfhi;
		logic       isMflo;
		logic       isMfc0;
		logic       cp0Write;
		logic       cp0ToReg;
		logic       reservedInstr;
		logic       isBreak;
		logic       isSyscall;
		logic       isEret;
		aluOpT      aluOp;
		logic [5:0] funct;
		branchCondT branchCond;
		logic       isJump;     // j, jal
		logic       isJumpReg;  // jr, jalr
		logic       isLink;
	} ctrlBundle;

	typedef struct packed {
		ctrlBundle              ctrl;
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       rsVal;
		logic [`XLEN-1:0]       rtVal;
		logic [`XLEN-1:0]       immExt;
		logic [4:0]             shamt;
		logic [`REG_ADDR_W-1:0] destReg;
		logic [`XLEN-1:0]       linkVal;
		instrWord               instr;
	} exBundle;

	typedef struct packed {
		logic                   en;
		logic [`REG_ADDR_W-1:0] addr;
		logic [`XLEN-1:0]       data;
	} wbPort;

endpackage

// ==== decode/mainDecoder.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module mainDecoder (
	input  mipsPkg::instrWord  instr,
	output mipsPkg::ctrlBundle ctrl
);
	import mipsPkg::*;

	logic [5:0] opCode;
	logic [5:0] fnCode;
	logic [4:0] rsCode;
	logic [4:0] rtCode;
	logic [4:0] saCode;

	assign opCode = instr.rFmt.op;
	assign fnCode = instr.rFmt.funct;
	assign rsCode = instr.rFmt.rs;
	assign rtCode = instr.rFmt.rt;
	assign saCode = instr.rFmt.shamt;

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = useless;
		ctrl.regDst = rd;
		ctrl.funct = fnCode;
		ctrl.signExt = (opCode[5:2] != 4'b0011);   // andi/ori/xori/lui zero-extend
		case (opCode)
			`R_TYPE: begin
				ctrl.aluOp = rType;
				case (fnCode)
					`ADD, `ADDU, `SUB, `SUBU, `SLT, `SLTU, `AND, `OR, `XOR, `NOR,
					`SLL, `SRA, `SLLV, `SRAV, `MOVN, `MOVZ:
						ctrl.regWrite = 1'b1;
					`SRL: begin
						ctrl.regWrite = 1'b1;
						if (rsCode[0])
							ctrl.aluOp = rotr;
					end
					`SRLV: begin
						ctrl.regWrite = 1'b1;
						if (saCode[0])
							ctrl.aluOp = rotrv;
					end
					`MFHI, `MFLO: begin
						ctrl.regWrite = 1'b1;
						ctrl.hiloToReg = 1'b1;
						ctrl.isMfhi = ~fnCode[1];
						ctrl.isMflo = fnCode[1];
					end
					`JR:
						ctrl.isJumpReg = 1'b1;
					`JALR: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDst = ra;    // operandPrep swaps this for rd
						ctrl.isJumpReg = 1'b1;
						ctrl.isLink = 1'b1;
					end
					`MULT, `MULTU, `DIV, `DIVU, `MTHI, `MTLO: ;   // hilo only
					`SYSCALL:
						ctrl.isSyscall = 1'b1;
					`BREAK:
						ctrl.isBreak = 1'b1;
					default: begin
						ctrl.aluOp = useless;
						ctrl.reservedInstr = 1'b1;
					end
				endcase
			end
			`ADDI, `ADDIU, `SLTI, `SLTIU, `ANDI, `ORI, `XORI, `LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = rt;
				ctrl.useImm = 1'b1;
				// low opcode bits pick the op within the 001xxx group
				case (opCode[2:0])
					3'd0: ctrl.aluOp = addi;
					3'd1: ctrl.aluOp = addiu;
					3'd2: ctrl.aluOp = slti;
					3'd3: ctrl.aluOp = sltiu;
					3'd4: ctrl.aluOp = andi;
					3'd5: ctrl.aluOp = ori;
					3'd6: ctrl.aluOp = xori;
					default: ctrl.aluOp = lui;
				endcase
			end
			`BEQ:  ctrl.branchCond = eq;
			`BNE:  ctrl.branchCond = ne;
			`BLEZ: ctrl.branchCond = lez;
			`BGTZ: ctrl.branchCond = gtz;
			`REGIMM_INST: begin
				case (rtCode)
					`BLTZ: ctrl.branchCond = ltz;
					`BGEZ: ctrl.branchCond = gez;
					`BLTZAL, `BGEZAL: begin
						ctrl.branchCond = rtCode[0] ? gez : ltz;
						ctrl.regWrite = 1'b1;
						ctrl.regDst = ra;
						ctrl.isLink = 1'b1;
					end
					default: ctrl.reservedInstr = 1'b1;
				endcase
			end
			`LB, `LH, `LWL, `LW, `LBU, `LHU, `LWR, `LL: begin
				ctrl.aluOp = mem;
				ctrl.regWrite = 1'b1;
				ctrl.regDst = rt;
				ctrl.useImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			`SB, `SH, `SWL, `SW, `SWR: begin
				ctrl.aluOp = mem;
				ctrl.useImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			`J:
				ctrl.isJump = 1'b1;
			`JAL: begin
				ctrl.isJump = 1'b1;
				ctrl.isLink = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.regDst = ra;
			end
			`COP0_INST: begin
				case (rsCode)
					`MTC0: begin
						ctrl.aluOp = mtc0;
						ctrl.cp0Write = 1'b1;
					end
					`MFC0: begin
						ctrl.aluOp = mfc0;
						ctrl.isMfc0 = 1'b1;
						ctrl.cp0ToReg = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.regDst = rt;
					end
					default: begin
						// eret only on the exact word
						ctrl.isEret = (instr.jFmt.index26 == `ERET);
						ctrl.reservedInstr = ~ctrl.isEret;
					end
				endcase
			end
			`SPECIAL2_INST: begin
				case (fnCode)
					`CLO: ctrl.aluOp = clo;
					`CLZ: ctrl.aluOp = clz;
					`MUL: ctrl.aluOp = mul;
					`MADD: ctrl.aluOp = madd;
					`MADDU: ctrl.aluOp = maddu;
					`MSUB: ctrl.aluOp = msub;
					`MSUBU: ctrl.aluOp = msubu;
					default: ctrl.reservedInstr = 1'b1;
				endcase
				ctrl.regWrite = (fnCode == `CLO) || (fnCode == `CLZ) || (fnCode == `MUL);
			end
			`SPECIAL3_INST: begin
				case (fnCode)
					`BSHFL: begin
						ctrl.regWrite = 1'b1;
						case (saCode)
							`SEB: ctrl.aluOp = seb;
							`SEH: ctrl.aluOp = seh;
							`WSBH: ctrl.aluOp = wsbh;
							default: begin
								ctrl.regWrite = 1'b0;
								ctrl.reservedInstr = 1'b1;
							end
						endcase
					end
					`EXT, `INS: begin
						ctrl.aluOp = fnCode[2] ? ins : ext;
						ctrl.regWrite = 1'b1;
						ctrl.regDst = rt;   // ext/ins write rt
					end
					default: ctrl.reservedInstr = 1'b1;
				endcase
			end
			default: ctrl.reservedInstr = 1'b1;
		endcase
	end

endmodule

// ==== decode/branchUnit.sv ====
`timescale 1ns/100ps

module branchUnit (
	input  mipsPkg::instrWord  instr,
	input  mipsPkg::ctrlBundle ctrl,
	input  logic [31:0]        pc,
	input  logic [31:0]        rsVal,
	input  logic [31:0]        rtVal,
	input  logic               instrValid,
	input  logic               stall,
	output logic               redirect,
	output logic [31:0]        redirectPc
);
	import mipsPkg::*;

	logic [31:0] pcPlus4;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic        condMet;

	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + {{14{instr.iFmt.imm16[15]}}, instr.iFmt.imm16, 2'b00};
	assign jumpTarget = {pcPlus4[31:28], instr.jFmt.index26, 2'b00};

	// signed tests are rs against zero
	always_comb begin
		case (ctrl.branchCond)
			eq:  condMet = (rsVal == rtVal);
			ne:  condMet = (rsVal != rtVal);
			lez: condMet = ($signed(rsVal) <= 0);
			gtz: condMet = ($signed(rsVal) > 0);
			ltz: condMet = rsVal[31];
			gez: condMet = ~rsVal[31];
			default: condMet = 1'b0;
		endcase
	end

	always_comb begin
		if (ctrl.isJumpReg)
			redirectPc = rsVal;
		else if (ctrl.isJump)
			redirectPc = jumpTarget;
		else
			redirectPc = branchTarget;
	end

	// once per accepted instruction
	assign redirect = instrValid && !stall && (condMet || ctrl.isJump || ctrl.isJumpReg);

endmodule

// ==== decode/operandPrep.sv ====
`timescale 1ns/100ps

module operandPrep (
	input  mipsPkg::instrWord  instr,
	input  mipsPkg::ctrlBundle ctrl,
	input  logic [31:0]        pc,
	output logic [31:0]        immExt,
	output logic [4:0]         destReg,
	output logic [31:0]        linkVal
);
	import mipsPkg::*;

	assign immExt = ctrl.signExt ? {{16{instr.iFmt.imm16[15]}}, instr.iFmt.imm16}
		: {16'h0000, instr.iFmt.imm16};

	always_comb begin
		if (ctrl.isJumpReg && ctrl.isLink) begin
			destReg = instr.rFmt.rd;    // jalr links into rd
		end else begin
			case (ctrl.regDst)
				rd: destReg = instr.rFmt.rd;
				rt: destReg = instr.iFmt.rt;
				ra: destReg = 5'd31;
				default: destReg = instr.rFmt.rd;
			endcase
		end
	end

	// return address skips the delay slot
	assign linkVal = pc + 32'd8;

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/100ps

module regFile (
	input  logic          clk,
	input  logic          rstN,
	input  logic [4:0]    raddrA,
	input  logic [4:0]    raddrB,
	output logic [31:0]   rdataA,
	output logic [31:0]   rdataB,
	input  mipsPkg::wbPort wb
);

	logic [31:0] regs [1:31];   // r0 not stored

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.en && wb.addr != 5'd0) begin
			regs[wb.addr] <= wb.data;
		end
	end

	function automatic logic [31:0] readReg(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		else if (wb.en && wb.addr == addr)
			return wb.data;     // write-through
		else
			return regs[addr];
	endfunction

	always_comb begin
		rdataA = readReg(raddrA);
		rdataB = readReg(raddrB);
	end

endmodule

// ==== hdl/idExReg.sv ====
`timescale 1ns/100ps

module idExReg (
	input  logic             clk,
	input  logic             rstN,
	input  logic             stall,
	input  logic             inValid,
	input  mipsPkg::exBundle inBus,
	output mipsPkg::exBundle exBus,
	output logic             exValid
);

	always_ff @(posedge clk) begin
		if (!rstN)
			exValid <= 1'b0;
		else if (!stall)
			exValid <= inValid;   // drops to 0 on an empty slot
	end

	always_ff @(posedge clk) begin
		if (!stall)
			exBus <= inBus;
	end

endmodule

// ==== hdl/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
	input  logic              clk,
	input  logic              rstN,
	input  logic              instrValid,
	input  mipsPkg::instrWord instr,
	input  logic [31:0]       pc,
	input  logic              stall,
	input  mipsPkg::wbPort    wb,
	output mipsPkg::exBundle  exBus,
	output logic              exValid,
	output logic              redirect,
	output logic [31:0]       redirectPc
);
	import mipsPkg::*;

	ctrlBundle   ctrl;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic [31:0] immExt;
	logic [31:0] linkVal;
	logic [4:0]  destReg;

	mainDecoder mainDecoder_inst (
		.instr (instr),
		.ctrl  (ctrl)
	);

	regFile regFile_inst (
		.clk    (clk),
		.rstN   (rstN),
		.raddrA (instr.rFmt.rs),
		.raddrB (instr.rFmt.rt),
		.rdataA (rsVal),
		.rdataB (rtVal),
		.wb     (wb)
	);

	operandPrep operandPrep_inst (
		.instr   (instr),
		.ctrl    (ctrl),
		.pc      (pc),
		.immExt  (immExt),
		.destReg (destReg),
		.linkVal (linkVal)
	);

	branchUnit branchUnit_inst (
		.instr      (instr),
		.ctrl       (ctrl),
		.pc         (pc),
		.rsVal      (rsVal),
		.rtVal      (rtVal),
		.instrValid (instrValid),
		.stall      (stall),
		.redirect   (redirect),
		.redirectPc (redirectPc)
	);

	idExReg idExReg_inst (
		.clk     (clk),
		.rstN    (rstN),
		.stall   (stall),
		.inValid (instrValid),
		.inBus   (exBundle'{ctrl: ctrl, pc: pc, rsVal: rsVal, rtVal: rtVal,
			immExt: immExt, shamt: instr.rFmt.shamt, destReg: destReg,
			linkVal: linkVal, instr: instr}),
		.exBus   (exBus),
		.exValid (exValid)
	);

endmodule

// ==== sim/decodeStageTb.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module decodeStageTb;
	import mipsPkg::*;

	localparam int CYCLES_PER_TEST = 300;
	localparam int NUM_TESTS = 6;
	localparam int RESET_CYCLES = 2;
	localparam int DRAIN_CYCLES = 3;
	localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST + DRAIN_CYCLES + 1;
	localparam int CYCLE_LIMIT = 2 * TOTAL_CYCLES;

	logic        clk;
	logic        rstN;
	logic        instrValid;
	instrWord    instr;
	logic [31:0] pc;
	logic        stall;
	wbPort       wb;
	exBundle     exBus;
	logic        exValid;
	logic        redirect;
	logic [31:0] redirectPc;

	integer      seed;
	int          cycleCount;
	int          errCount;
	int          checkCount;
	int          accepted;
	logic [31:0] shadow [0:31];   // model copy of the register file
	logic        expValid;
	exBundle     expBus;

	logic [5:0] aluFn [0:21];
	logic [5:0] memOp [0:12];
	logic [5:0] spec2Fn [0:6];
	logic [5:0] spec3Fn [0:2];
	logic [4:0] bshflSa [0:2];
	logic [5:0] unusedOp [0:5];

	decodeStage decodeStage_inst (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.pc         (pc),
		.stall      (stall),
		.wb         (wb),
		.exBus      (exBus),
		.exValid    (exValid),
		.redirect   (redirect),
		.redirectPc (redirectPc)
	);

	always #5 clk = ~clk;

	function automatic int randBelow(int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic logic [31:0] regRead(logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		if (wb.en && wb.addr == addr)
			return wb.data;   // same-cycle write wins
		return shadow[addr];
	endfunction

	// reference decode from the instruction tables
	function automatic ctrlBundle decodeRef(instrWord w);
		ctrlBundle c;
		logic [5:0] op;
		logic [5:0] fn;
		op = w.rFmt.op;
		fn = w.rFmt.funct;
		c = '0;
		c.aluOp = useless;
		c.regDst = rd;
		c.funct = fn;
		c.signExt = !(op == `ANDI || op == `ORI || op == `XORI || op == `LUI);
		case (op)
			`R_TYPE: begin
				c.aluOp = rType;
				case (fn)
					`ADD, `ADDU, `SUB, `SUBU, `AND, `OR, `XOR, `NOR, `SLT, `SLTU,
					`SLL, `SRA, `SLLV, `SRAV, `MOVZ, `MOVN:
						c.regWrite = 1'b1;
					`SRL: begin
						c.regWrite = 1'b1;
						c.aluOp = w.rFmt.rs[0] ? rotr : rType;   // R bit
					end
					`SRLV: begin
						c.regWrite = 1'b1;
						c.aluOp = w.rFmt.shamt[0] ? rotrv : rType;
					end
					`MFHI, `MFLO: begin
						c.regWrite = 1'b1;
						c.hiloToReg = 1'b1;
						c.isMfhi = (fn == `MFHI);
						c.isMflo = (fn == `MFLO);
					end
					`JR:
						c.isJumpReg = 1'b1;
					`JALR: begin
						c.isJumpReg = 1'b1;
						c.isLink = 1'b1;
						c.regWrite = 1'b1;
						c.regDst = ra;
					end
					`MULT, `MULTU, `DIV, `DIVU, `MTHI, `MTLO: ;
					`SYSCALL:
						c.isSyscall = 1'b1;
					`BREAK:
						c.isBreak = 1'b1;
					default: begin
						c.reservedInstr = 1'b1;
						c.aluOp = useless;
					end
				endcase
			end
			`ADDI, `ADDIU, `SLTI, `SLTIU, `ANDI, `ORI, `XORI, `LUI: begin
				c.regWrite = 1'b1;
				c.useImm = 1'b1;
				c.regDst = rt;
				case (op)
					`ADDI: c.aluOp = addi;
					`ADDIU: c.aluOp = addiu;
					`SLTI: c.aluOp = slti;
					`SLTIU: c.aluOp = sltiu;
					`ANDI: c.aluOp = andi;
					`ORI: c.aluOp = ori;
					`XORI: c.aluOp = xori;
					default: c.aluOp = lui;
				endcase
			end
			`LB, `LH, `LWL, `LW, `LBU, `LHU, `LWR, `LL: begin
				c.aluOp = mem;
				c.useImm = 1'b1;
				c.regWrite = 1'b1;
				c.regDst = rt;
				c.memRead = 1'b1;
				c.memToReg = 1'b1;
			end
			`SB, `SH, `SWL, `SW, `SWR: begin
				c.aluOp = mem;
				c.useImm = 1'b1;
				c.memWrite = 1'b1;
			end
			`BEQ: c.branchCond = eq;
			`BNE: c.branchCond = ne;
			`BLEZ: c.branchCond = lez;
			`BGTZ: c.branchCond = gtz;
			`REGIMM_INST: begin
				case (w.rFmt.rt)
					`BLTZ, `BLTZAL: c.branchCond = ltz;
					`BGEZ, `BGEZAL: c.branchCond = gez;
					default: c.reservedInstr = 1'b1;
				endcase
				if (w.rFmt.rt == `BLTZAL || w.rFmt.rt == `BGEZAL) begin
					c.isLink = 1'b1;
					c.regWrite = 1'b1;
					c.regDst = ra;
				end
			end
			`J:
				c.isJump = 1'b1;
			`JAL: begin
				c.isJump = 1'b1;
				c.isLink = 1'b1;
				c.regWrite = 1'b1;
				c.regDst = ra;
			end
			`COP0_INST: begin
				if (w.rFmt.rs == `MTC0) begin
					c.aluOp = mtc0;
					c.cp0Write = 1'b1;
				end else if (w.rFmt.rs == `MFC0) begin
					c.aluOp = mfc0;
					c.isMfc0 = 1'b1;
					c.cp0ToReg = 1'b1;
					c.regWrite = 1'b1;
					c.regDst = rt;
				end else if (w.jFmt.index26 == `ERET) begin
					c.isEret = 1'b1;
				end else begin
					c.reservedInstr = 1'b1;
				end
			end
			`SPECIAL2_INST: begin
				case (fn)
					`MADD: c.aluOp = madd;
					`MADDU: c.aluOp = maddu;
					`MSUB: c.aluOp = msub;
					`MSUBU: c.aluOp = msubu;
					`MUL: c.aluOp = mul;
					`CLZ: c.aluOp = clz;
					`CLO: c.aluOp = clo;
					default: c.reservedInstr = 1'b1;
				endcase
				c.regWrite = (c.aluOp == mul || c.aluOp == clz || c.aluOp == clo);
			end
			`SPECIAL3_INST: begin
				if (fn == `BSHFL) begin
					case (w.rFmt.shamt)
						`SEB: c.aluOp = seb;
						`SEH: c.aluOp = seh;
						`WSBH: c.aluOp = wsbh;
						default: c.reservedInstr = 1'b1;
					endcase
				end else if (fn == `EXT || fn == `INS) begin
					c.aluOp = (fn == `EXT) ? ext : ins;
					c.regDst = rt;
				end else begin
					c.reservedInstr = 1'b1;
				end
				c.regWrite = !c.reservedInstr;
			end
			default: c.reservedInstr = 1'b1;
		endcase
		return c;
	endfunction

	function automatic instrWord pickWord(int kind);
		instrWord w;
		int sel;
		w = $random(seed);   // unused fields stay random
		sel = randBelow(8);
		case (kind)
			0: begin
				if (sel < 3) begin
					w.rFmt.op = `R_TYPE;
					w.rFmt.funct = aluFn[randBelow(22)];
				end else if (sel < 6) begin
					w.rFmt.op = `ADDI + 6'(randBelow(8));
				end else if (sel == 6) begin
					w.rFmt.op = `SPECIAL2_INST;
					w.rFmt.funct = spec2Fn[randBelow(7)];
				end else begin
					w.rFmt.op = `SPECIAL3_INST;
					w.rFmt.funct = spec3Fn[randBelow(3)];
					if (w.rFmt.funct == `BSHFL)
						w.rFmt.shamt = bshflSa[randBelow(3)];
				end
			end
			1: w.rFmt.op = memOp[randBelow(13)];
			2: begin
				sel = randBelow(6);
				if (sel < 4) begin
					w.rFmt.op = `BEQ + 6'(sel);
				end else begin
					w.rFmt.op = `REGIMM_INST;
					w.rFmt.rt = (sel == 4) ? `BLTZ : `BGEZ;
				end
				if (sel < 2 && randBelow(2) == 1)
					w.rFmt.rt = w.rFmt.rs;   // equal operands
			end
			3: begin
				sel = randBelow(6);
				case (sel)
					0: w.jFmt.op = `J;
					1: w.jFmt.op = `JAL;
					2, 3: begin
						w.rFmt.op = `R_TYPE;
						w.rFmt.funct = (sel == 2) ? `JR : `JALR;
					end
					default: begin
						w.rFmt.op = `REGIMM_INST;
						w.rFmt.rt = (sel == 4) ? `BGEZAL : `BLTZAL;
					end
				endcase
			end
			default: begin
				case (sel)
					0, 1: begin
						w.rFmt.op = `R_TYPE;
						w.rFmt.funct = (sel == 0) ? `BREAK : `SYSCALL;
					end
					2: w = {`COP0_INST, `ERET};
					3, 4: begin
						w.rFmt.op = `COP0_INST;
						w.rFmt.rs = (sel == 3) ? `MTC0 : `MFC0;
					end
					5: ;   // fully random word
					6: w.rFmt.op = unusedOp[randBelow(6)];
					default: w = {`COP0_INST, `ERET} ^ (32'd1 << randBelow(26));   // near miss
				endcase
			end
		endcase
		return w;
	endfunction

	task automatic expectValid(logic got, logic want, string what);
		checkCount++;
		if (got !== want) begin
			errCount++;
			$display("FAILED at %0.1f ns: exValid %b, expected %b (%s)", $realtime, got, want, what);
		end
	endtask

	task automatic checkCtrl(ctrlBundle got, ctrlBundle want, instrWord w);
		checkCount++;
		if (got !== want) begin
			errCount++;
			$display("FAILED at %0.1f ns: ctrl for instr %08h is %h, expected %h",
				$realtime, w, got, want);
		end
	endtask

	task automatic checkBus(exBundle got, exBundle want);
		checkCount++;
		got.ctrl = want.ctrl;   // ctrl has its own check
		if (got !== want) begin
			errCount++;
			$display("FAILED at %0.1f ns: exBus for pc %08h is %h, expected %h",
				$realtime, want.pc, got, want);
		end
	endtask

	task automatic checkRedirect(logic gotFlag, logic [31:0] gotPc, logic wantFlag,
		logic [31:0] wantPc, instrWord w);
		checkCount++;
		if (gotFlag !== wantFlag || (wantFlag && gotPc !== wantPc)) begin
			errCount++;
			$display("FAILED at %0.1f ns: redirect %b/%08h for instr %08h, expected %b/%08h",
				$realtime, gotFlag, gotPc, w, wantFlag, wantPc);
		end
	endtask

	// runs at the falling edge once inputs and outputs have settled
	task automatic compareOutputs();
		ctrlBundle   c;
		exBundle     e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pc4;
		logic [31:0] target;
		logic        taken;
		expectValid(exValid, expValid, "registered stage");
		if (expValid) begin
			checkCtrl(exBus.ctrl, expBus.ctrl, expBus.instr);
			checkBus(exBus, expBus);
		end
		c = decodeRef(instr);
		a = regRead(instr.rFmt.rs);
		b = regRead(instr.rFmt.rt);
		case (c.branchCond)
			eq: taken = (a == b);
			ne: taken = (a != b);
			lez: taken = ($signed(a) < 1);
			gtz: taken = ($signed(a) >= 1);
			ltz: taken = ($signed(a) < 0);
			gez: taken = ($signed(a) >= 0);
			default: taken = 1'b0;
		endcase
		taken = taken || c.isJump || c.isJumpReg;
		pc4 = pc + 32'd4;
		if (c.isJumpReg)
			target = a;
		else if (c.isJump)
			target = {pc4[31:28], instr.jFmt.index26, 2'b00};
		else
			target = pc4 + (32'($signed(instr.iFmt.imm16)) << 2);
		checkRedirect(redirect, redirectPc, instrValid && !stall && taken, target, instr);
		if (!stall) begin
			e.ctrl = c;
			e.pc = pc;
			e.rsVal = a;
			e.rtVal = b;
			e.immExt = c.signExt ? 32'($signed(instr.iFmt.imm16)) : 32'(instr.iFmt.imm16);
			e.shamt = instr.rFmt.shamt;
			if (instr.rFmt.op == `R_TYPE && instr.rFmt.funct == `JALR)
				e.destReg = instr.rFmt.rd;
			else if (c.regDst == rt)
				e.destReg = instr.iFmt.rt;
			else if (c.regDst == ra)
				e.destReg = 5'd31;
			else
				e.destReg = instr.rFmt.rd;
			e.linkVal = pc + 32'd8;
			e.instr = instr;
			expBus = e;
			expValid = instrValid;
			if (instrValid)
				accepted++;
		end
		if (wb.en && wb.addr != 5'd0)
			shadow[wb.addr] = wb.data;   // lands at the coming edge
	endtask

	task automatic stepCycle(int kind, int stallPct, int validPct);
		instrWord w;
		wbPort    p;
		logic     hold;
		@(posedge clk);
		hold = instrValid && stall;   // producer keeps a stalled word
		if (hold) begin
			w = instr;
		end else begin
			w = pickWord((kind == 5) ? randBelow(5) : kind);
			instr <= w;
			pc <= $random(seed) & 32'hffff_fffc;
			instrValid <= (randBelow(100) < validPct);
		end
		stall <= (randBelow(100) < stallPct);
		p.en = (randBelow(2) == 1);
		if (randBelow(3) == 0)
			p.addr = (randBelow(2) == 1) ? w.rFmt.rs : w.rFmt.rt;
		else
			p.addr = 5'(randBelow(32));
		p.data = (randBelow(5) == 0) ? 32'd0 : $random(seed);
		wb <= p;
		@(negedge clk);
		compareOutputs();
	endtask

	task automatic runTest(string name, int kind, int stallPct);
		int errBefore;
		errBefore = errCount;
		accepted = 0;
		for (int i = 0; i < CYCLES_PER_TEST; i++)
			stepCycle(kind, stallPct, 85);
		$display("test %-10s %0d cycles, %0d accepted, %0d errors",
			name, CYCLES_PER_TEST, accepted, errCount - errBefore);
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("run stopped: no end of test after %0d cycles", CYCLE_LIMIT);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		seed = 32'h845d_8b9a;
		clk = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		stall = 1'b0;
		wb = '0;
		errCount = 0;
		checkCount = 0;
		expValid = 1'b0;
		expBus = '0;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;
		aluFn = '{`ADD, `ADDU, `SUB, `SUBU, `AND, `OR, `XOR, `NOR, `SLT, `SLTU, `SLL,
			`SRL, `SRA, `SLLV, `SRLV, `SRAV, `MOVZ, `MOVN, `MFHI, `MFLO, `MULT, `DIVU};
		memOp = '{`LB, `LH, `LWL, `LW, `LBU, `LHU, `LWR, `LL, `SB, `SH, `SWL, `SW, `SWR};
		spec2Fn = '{`MADD, `MADDU, `MUL, `MSUB, `MSUBU, `CLZ, `CLO};
		spec3Fn = '{`EXT, `INS, `BSHFL};
		bshflSa = '{`WSBH, `SEB, `SEH};
		unusedOp = '{6'b010001, 6'b010010, 6'b011000, 6'b110001, 6'b111000, 6'b111111};

		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		expectValid(exValid, 1'b0, "after reset");
		$display("test %-10s exValid %b, %0d errors", "reset", exValid, errCount);

		runTest("alu/imm", 0, 10);
		runTest("load/store", 1, 10);
		runTest("branch", 2, 10);
		runTest("jump/link", 3, 10);
		runTest("trap/cop0", 4, 10);
		runTest("stall", 5, 50);
		// empty slots flush the last bundle out
		repeat (DRAIN_CYCLES) stepCycle(0, 0, 0);

		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+common
common/mipsPkg.sv
decode/mainDecoder.sv
decode/branchUnit.sv
decode/operandPrep.sv
hdl/regFile.sv
hdl/idExReg.sv
hdl/decodeStage.sv
sim/decodeStageTb.sv
